//--- hdl/dma_cfg_pkg.sv
// -------------------------------------
// Copy engine configuration
// Bus widths and the data-path types shared
// by decode, execute and the top level
// -------------------------------------
package dma_cfg_pkg;

    // Bus geometry
    localparam int unsigned DataWidth     = 32;
    localparam int unsigned AddrWidth     = 16;
    localparam int unsigned TFLenWidth    = 12;
    localparam int unsigned StrbWidth     = DataWidth / 8;
    localparam int unsigned OffsetWidth   = $clog2(StrbWidth);

    // AXI4 INCR burst limit
    localparam int unsigned MaxBurstBeats = 256;

    // Byte address
    typedef logic [AddrWidth-1:0]  addr_t;
    // One bus word
    typedef logic [DataWidth-1:0]  data_t;
    // One enable per byte lane
    typedef logic [StrbWidth-1:0]  strb_t;
    // Transfer length in bytes
    typedef logic [TFLenWidth-1:0] tf_len_t;
    // AxLEN field, beat count minus one
    typedef logic [$clog2(MaxBurstBeats)-1:0] beats_t;

endpackage

//--- hdl/dma_bus_pkg.sv
// -------------------------------------
// Copy engine bus encodings
// AXI write response codes and the error
// kinds reported back to the requester
// -------------------------------------
package dma_bus_pkg;

    // AXI4 BRESP encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Why a transfer failed
    typedef enum logic [1:0] {
        ERR_NONE     = 2'd0,
        // Rejected in decode, never reaches the bus
        ERR_ZERO_LEN = 2'd1,
        // SLVERR or DECERR on B
        ERR_BUS      = 2'd2
    } err_kind_e;

endpackage

//--- hdl/dma_desc_if.sv
// -------------------------------------
// Burst descriptor channel
// One AXI burst per descriptor, handed from
// decode to execute with valid/ready
// -------------------------------------
interface dma_desc_if;
    import dma_cfg_pkg::*;

    // Handshake
    logic   desc_valid;
    logic   desc_ready;

    // Burst payload
    addr_t  src_addr;
    addr_t  dst_addr;
    // Beat count minus one
    beats_t num_beats;
    strb_t  first_strb;
    strb_t  last_strb;

    modport decode (
        output desc_valid, src_addr, dst_addr, num_beats, first_strb, last_strb,
        input  desc_ready
    );

    modport execute (
        input  desc_valid, src_addr, dst_addr, num_beats, first_strb, last_strb,
        output desc_ready
    );

endinterface

//--- hdl/dma_decode.sv
// -------------------------------------
// Copy engine decode stage
// Registers one request, filters zero lengths
// and computes burst length and strobes
// -------------------------------------
module dma_decode (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  dma_cfg_pkg::addr_t   req_src_addr_i,
    input  dma_cfg_pkg::addr_t   req_dst_addr_i,
    input  dma_cfg_pkg::tf_len_t req_length_i,
    input  logic                 req_last_i,
    dma_desc_if.decode           desc,
    output logic                 meta_push_o,
    output logic                 meta_last_o,
    output logic                 meta_zero_len_o,
    input  logic                 meta_ready_i,
    output logic                 busy_o
);
    import dma_cfg_pkg::*;

    logic                   zero_len;
    logic                   accept;
    logic                   desc_valid_q;
    logic [OffsetWidth-1:0] dst_off;
    logic [OffsetWidth-1:0] tail;
    // One spare bit so length plus offset cannot wrap
    logic [TFLenWidth:0]    span;
    logic [TFLenWidth:0]    span_m1;

    assign zero_len = (req_length_i == '0);

    // Zero lengths only need room in the metadata queue
    assign req_ready_o = meta_ready_i & (zero_len | ~desc_valid_q | desc.desc_ready);
    assign accept      = req_valid_i & req_ready_o;

    // Every accepted request leaves a metadata entry for result
    assign meta_push_o     = accept;
    assign meta_last_o     = req_last_i;
    assign meta_zero_len_o = zero_len;

    // -------------------------------------
    // Burst geometry
    // -------------------------------------
    assign dst_off = req_dst_addr_i[OffsetWidth-1:0];
    assign span    = (TFLenWidth+1)'(req_length_i) + (TFLenWidth+1)'(dst_off);
    assign span_m1 = span - (TFLenWidth+1)'(1);
    // Bytes used in the final word, 0 means full
    assign tail    = span[OffsetWidth-1:0];

    // Descriptor payload, loaded on acceptance only
    always_ff @(posedge clk_i) begin
        if (accept && !zero_len) begin
            desc.src_addr   <= req_src_addr_i;
            desc.dst_addr   <= req_dst_addr_i;
            desc.num_beats  <= span_m1[OffsetWidth +: $bits(beats_t)];
            // Lanes at or above the destination offset
            desc.first_strb <= strb_t'('1) << dst_off;
            // Lanes below the tail
            desc.last_strb  <= (tail == '0) ? strb_t'('1) : ~(strb_t'('1) << tail);
        end
    end

    // Descriptor valid from the cycle after acceptance until taken
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            desc_valid_q <= 1'b0;
        end else if (accept && !zero_len) begin
            desc_valid_q <= 1'b1;
        end else if (desc.desc_ready) begin
            desc_valid_q <= 1'b0;
        end
    end

    assign desc.desc_valid = desc_valid_q;
    assign busy_o          = desc_valid_q;

endmodule

//--- hdl/dma_execute.sv
// -------------------------------------
// Copy engine datapath
// Whole-word OBI reads into an in-order
// buffer, drained as one AXI write burst
// -------------------------------------
module dma_execute #(
    parameter int unsigned BufferDepth       = 3,
    parameter int unsigned NumBurstsInFlight = 2
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    dma_desc_if.execute         desc,
    output logic                obi_req_o,
    output dma_cfg_pkg::addr_t  obi_addr_o,
    input  logic                obi_gnt_i,
    input  logic                obi_rvalid_i,
    input  dma_cfg_pkg::data_t  obi_rdata_i,
    output logic                aw_valid_o,
    output dma_cfg_pkg::addr_t  aw_addr_o,
    output dma_cfg_pkg::beats_t aw_len_o,
    input  logic                aw_ready_i,
    output logic                w_valid_o,
    output dma_cfg_pkg::data_t  w_data_o,
    output dma_cfg_pkg::strb_t  w_strb_o,
    output logic                w_last_o,
    input  logic                w_ready_i,
    output logic                busy_o
);
    import dma_cfg_pkg::*;

    localparam int unsigned BufIdxW   = (BufferDepth > 1) ? $clog2(BufferDepth) : 1;
    localparam int unsigned BufCntW   = $clog2(BufferDepth + 1);
    localparam int unsigned JobIdxW   = (NumBurstsInFlight > 1) ? $clog2(NumBurstsInFlight) : 1;
    localparam int unsigned JobCntW   = $clog2(NumBurstsInFlight + 1);
    localparam int unsigned WordAddrW = AddrWidth - OffsetWidth;

    logic                 take;
    // Read side
    logic                 rd_active_q;
    logic [WordAddrW-1:0] rd_addr_q;
    beats_t               rd_left_q;
    logic [BufCntW-1:0]   rd_pend_q;
    logic                 rd_issue;
    // Word buffer
    data_t                buf_mem [BufferDepth];
    logic [BufIdxW-1:0]   buf_wr_q;
    logic [BufIdxW-1:0]   buf_rd_q;
    logic [BufCntW-1:0]   buf_cnt_q;
    logic                 buf_pop;
    // Write job queue
    beats_t               job_beats [NumBurstsInFlight];
    strb_t                job_first [NumBurstsInFlight];
    strb_t                job_last  [NumBurstsInFlight];
    logic [JobIdxW-1:0]   job_wr_q;
    logic [JobIdxW-1:0]   job_rd_q;
    logic [JobCntW-1:0]   job_cnt_q;
    logic                 job_pop;
    beats_t               w_beat_q;
    logic                 w_ok;

    // New descriptor once reads are done, AW is free and a job slot is open
    assign desc.desc_ready = ~rd_active_q & ~aw_valid_o &
                             (job_cnt_q != JobCntW'(NumBurstsInFlight));
    assign take = desc.desc_valid & desc.desc_ready;

    // -------------------------------------
    // OBI read side
    // -------------------------------------
    // Only ask while the buffer can absorb every read in flight
    assign obi_req_o  = rd_active_q & ((buf_cnt_q + rd_pend_q) < BufCntW'(BufferDepth));
    assign obi_addr_o = {rd_addr_q, OffsetWidth'(0)};
    assign rd_issue   = obi_req_o & obi_gnt_i;

    always_ff @(posedge clk_i) begin
        if (take) begin
            // Source aligned down to a word
            rd_addr_q <= desc.src_addr[AddrWidth-1:OffsetWidth];
        end else if (rd_issue) begin
            rd_addr_q <= rd_addr_q + WordAddrW'(1);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_active_q <= 1'b0;
            rd_left_q   <= '0;
            rd_pend_q   <= '0;
        end else begin
            if (take) begin
                rd_active_q <= 1'b1;
                rd_left_q   <= desc.num_beats;
            end else if (rd_issue) begin
                rd_active_q <= (rd_left_q != '0);
                rd_left_q   <= rd_left_q - beats_t'(1);
            end
            // Granted but not yet returned
            if (rd_issue && !obi_rvalid_i) begin
                rd_pend_q <= rd_pend_q + BufCntW'(1);
            end else if (!rd_issue && obi_rvalid_i) begin
                rd_pend_q <= rd_pend_q - BufCntW'(1);
            end
        end
    end

    // -------------------------------------
    // Word buffer
    // -------------------------------------
    always_ff @(posedge clk_i) begin
        if (obi_rvalid_i) begin
            buf_mem[buf_wr_q] <= obi_rdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            buf_wr_q  <= '0;
            buf_rd_q  <= '0;
            buf_cnt_q <= '0;
        end else begin
            if (obi_rvalid_i) begin
                buf_wr_q <= (buf_wr_q == BufIdxW'(BufferDepth - 1)) ? '0 : buf_wr_q + 1'b1;
            end
            if (buf_pop) begin
                buf_rd_q <= (buf_rd_q == BufIdxW'(BufferDepth - 1)) ? '0 : buf_rd_q + 1'b1;
            end
            if (obi_rvalid_i && !buf_pop) begin
                buf_cnt_q <= buf_cnt_q + BufCntW'(1);
            end else if (!obi_rvalid_i && buf_pop) begin
                buf_cnt_q <= buf_cnt_q - BufCntW'(1);
            end
        end
    end

    // -------------------------------------
    // AXI AW and W side
    // -------------------------------------
    always_ff @(posedge clk_i) begin
        if (take) begin
            aw_addr_o           <= desc.dst_addr;
            aw_len_o            <= desc.num_beats;
            job_beats[job_wr_q] <= desc.num_beats;
            job_first[job_wr_q] <= desc.first_strb;
            job_last[job_wr_q]  <= desc.last_strb;
        end
    end

    // The AW register always holds the newest job, so a lone job with
    // a pending AW has not been announced yet
    assign w_ok      = (job_cnt_q != '0) & ~(aw_valid_o & (job_cnt_q == JobCntW'(1)));
    assign w_valid_o = w_ok & (buf_cnt_q != '0);
    assign w_data_o  = buf_mem[buf_rd_q];
    assign w_last_o  = (w_beat_q == job_beats[job_rd_q]);
    assign buf_pop   = w_valid_o & w_ready_i;
    assign job_pop   = buf_pop & w_last_o;

    // Edge strobes by beat position, both on a single beat
    always_comb begin
        w_strb_o = '1;
        if (w_beat_q == '0) begin
            w_strb_o = w_strb_o & job_first[job_rd_q];
        end
        if (w_last_o) begin
            w_strb_o = w_strb_o & job_last[job_rd_q];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aw_valid_o <= 1'b0;
            job_wr_q   <= '0;
            job_rd_q   <= '0;
            job_cnt_q  <= '0;
            w_beat_q   <= '0;
        end else begin
            if (take) begin
                aw_valid_o <= 1'b1;
                job_wr_q   <= (job_wr_q == JobIdxW'(NumBurstsInFlight - 1)) ? '0 : job_wr_q + 1'b1;
            end else if (aw_ready_i) begin
                aw_valid_o <= 1'b0;
            end
            if (job_pop) begin
                job_rd_q <= (job_rd_q == JobIdxW'(NumBurstsInFlight - 1)) ? '0 : job_rd_q + 1'b1;
                w_beat_q <= '0;
            end else if (buf_pop) begin
                w_beat_q <= w_beat_q + beats_t'(1);
            end
            if (take && !job_pop) begin
                job_cnt_q <= job_cnt_q + JobCntW'(1);
            end else if (!take && job_pop) begin
                job_cnt_q <= job_cnt_q - JobCntW'(1);
            end
        end
    end

    assign busy_o = rd_active_q | aw_valid_o | (job_cnt_q != '0) |
                    (buf_cnt_q != '0) | (rd_pend_q != '0);

endmodule

//--- hdl/dma_result.sv
// -------------------------------------
// Copy engine response stage
// Keeps transfers in request order and
// turns B responses into replies
// -------------------------------------
module dma_result #(
    parameter int unsigned MetaFifoDepth = 5
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   meta_push_i,
    input  logic                   meta_last_i,
    input  logic                   meta_zero_len_i,
    output logic                   meta_ready_o,
    input  logic                   b_valid_i,
    input  dma_bus_pkg::axi_resp_e b_resp_i,
    output logic                   b_ready_o,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output dma_bus_pkg::err_kind_e rsp_err_kind_o,
    output logic                   rsp_last_o,
    output logic                   busy_o
);
    import dma_bus_pkg::*;

    localparam int unsigned IdxW = (MetaFifoDepth > 1) ? $clog2(MetaFifoDepth) : 1;
    localparam int unsigned CntW = $clog2(MetaFifoDepth + 1);

    logic            last_mem [MetaFifoDepth];
    logic            zero_mem [MetaFifoDepth];
    logic [IdxW-1:0] wr_q;
    logic [IdxW-1:0] rd_q;
    logic [CntW-1:0] cnt_q;
    logic [CntW-1:0] cnt_d;
    logic            head_valid;
    logic            head_zero;
    logic            pop;

    always_ff @(posedge clk_i) begin
        if (meta_push_i) begin
            last_mem[wr_q] <= meta_last_i;
            zero_mem[wr_q] <= meta_zero_len_i;
        end
    end

    assign head_valid = (cnt_q != '0);
    assign head_zero  = zero_mem[rd_q];

    // Zero-length heads answer at once, others ride on B
    assign rsp_valid_o = head_valid & (head_zero | b_valid_i);
    assign b_ready_o   = head_valid & ~head_zero & rsp_ready_i;
    assign rsp_last_o  = last_mem[rd_q];
    assign pop         = rsp_valid_o & rsp_ready_i;

    always_comb begin
        if (head_zero) begin
            rsp_err_kind_o = ERR_ZERO_LEN;
        end else if (b_resp_i == SLVERR || b_resp_i == DECERR) begin
            rsp_err_kind_o = ERR_BUS;
        end else begin
            rsp_err_kind_o = ERR_NONE;
        end
    end

    assign cnt_d = cnt_q + CntW'(meta_push_i) - CntW'(pop);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_q         <= '0;
            rd_q         <= '0;
            cnt_q        <= '0;
            meta_ready_o <= 1'b0;
        end else begin
            if (meta_push_i) begin
                wr_q <= (wr_q == IdxW'(MetaFifoDepth - 1)) ? '0 : wr_q + 1'b1;
            end
            if (pop) begin
                rd_q <= (rd_q == IdxW'(MetaFifoDepth - 1)) ? '0 : rd_q + 1'b1;
            end
            cnt_q        <= cnt_d;
            // Registered not-full flag
            meta_ready_o <= (cnt_d < CntW'(MetaFifoDepth));
        end
    end

    assign busy_o = head_valid;

endmodule

//--- hdl/dma_backend.sv
// -------------------------------------
// 1D copy engine top level
// OBI reads to AXI4 write bursts through
// decode, execute and result stages
// -------------------------------------
module dma_backend #(
    parameter int unsigned BufferDepth       = 3,
    parameter int unsigned NumBurstsInFlight = 2
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Transfer request
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  dma_cfg_pkg::addr_t     req_src_addr_i,
    input  dma_cfg_pkg::addr_t     req_dst_addr_i,
    input  dma_cfg_pkg::tf_len_t   req_length_i,
    input  logic                   req_last_i,
    // Transfer response
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output dma_bus_pkg::err_kind_e rsp_err_kind_o,
    output logic                   rsp_last_o,
    // OBI read manager
    output logic                   obi_req_o,
    output dma_cfg_pkg::addr_t     obi_addr_o,
    input  logic                   obi_gnt_i,
    input  logic                   obi_rvalid_i,
    input  dma_cfg_pkg::data_t     obi_rdata_i,
    // AXI4 write manager
    output logic                   aw_valid_o,
    output dma_cfg_pkg::addr_t     aw_addr_o,
    output dma_cfg_pkg::beats_t    aw_len_o,
    input  logic                   aw_ready_i,
    output logic                   w_valid_o,
    output dma_cfg_pkg::data_t     w_data_o,
    output dma_cfg_pkg::strb_t     w_strb_o,
    output logic                   w_last_o,
    input  logic                   w_ready_i,
    input  logic                   b_valid_i,
    input  dma_bus_pkg::axi_resp_e b_resp_i,
    output logic                   b_ready_o,
    // Bit 0 decode, bit 1 execute, bit 2 result
    output logic [2:0]             busy_o
);

    // Enough entries for every transfer that can be past decode
    localparam int unsigned MetaFifoDepth = BufferDepth + NumBurstsInFlight;

    logic meta_push;
    logic meta_last;
    logic meta_zero_len;
    logic meta_ready;
    logic dec_busy;
    logic exe_busy;
    logic res_busy;

    dma_desc_if desc0 ();

    dma_decode dec0 (
        .clk_i, .rst_n_i,
        .req_valid_i, .req_ready_o, .req_src_addr_i, .req_dst_addr_i, .req_length_i, .req_last_i,
        .desc            (desc0.decode),
        .meta_push_o     (meta_push),
        .meta_last_o     (meta_last),
        .meta_zero_len_o (meta_zero_len),
        .meta_ready_i    (meta_ready),
        .busy_o          (dec_busy)
    );

    dma_execute #(
        .BufferDepth       (BufferDepth),
        .NumBurstsInFlight (NumBurstsInFlight)
    ) exe0 (
        .clk_i, .rst_n_i,
        .desc   (desc0.execute),
        .obi_req_o, .obi_addr_o, .obi_gnt_i, .obi_rvalid_i, .obi_rdata_i,
        .aw_valid_o, .aw_addr_o, .aw_len_o, .aw_ready_i,
        .w_valid_o, .w_data_o, .w_strb_o, .w_last_o, .w_ready_i,
        .busy_o (exe_busy)
    );

    dma_result #(
        .MetaFifoDepth (MetaFifoDepth)
    ) res0 (
        .clk_i, .rst_n_i,
        .meta_push_i     (meta_push),
        .meta_last_i     (meta_last),
        .meta_zero_len_i (meta_zero_len),
        .meta_ready_o    (meta_ready),
        .b_valid_i, .b_resp_i, .b_ready_o,
        .rsp_valid_o, .rsp_ready_i, .rsp_err_kind_o, .rsp_last_o,
        .busy_o          (res_busy)
    );

    assign busy_o = {res_busy, exe_busy, dec_busy};

endmodule

//--- sim/tb_bus_models.sv
// ----------------------------------------
// Testbench bus models
// OBI read memory and AXI write slave,
// both with random stalls
// ----------------------------------------
module obi_mem_model (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req_i,
    input  dma_cfg_pkg::addr_t addr_i,
    output logic               gnt_o,
    output logic               rvalid_o,
    output dma_cfg_pkg::data_t rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import dma_cfg_pkg::*;

    logic  granted_q;
    addr_t addr_q;

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            granted_q <= 1'b0;
            addr_q    <= '0;
        end else begin
            granted_q <= req_i & gnt_o;
            addr_q    <= addr_i;
        end
    end

    // Data of a grant shows up in the following cycle
    always @(negedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gnt_o    <= 1'b0;
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
        end else begin
            gnt_o    <= ($urandom % 3) != 0;
            rvalid_o <= granted_q;
            rdata_o  <= {addr_q ^ 16'hc3a5, ~addr_q};
        end
    end
endmodule

module axi_wr_slave_model (
    input  logic                   clk_i, rst_n_i,
    input  dma_cfg_pkg::addr_t     win_lo_i, win_hi_i,
    input  logic                   aw_valid_i,
    input  dma_cfg_pkg::addr_t     aw_addr_i,
    output logic                   aw_ready_o,
    input  logic                   w_valid_i, w_last_i,
    output logic                   w_ready_o,
    output logic                   b_valid_o,
    output dma_bus_pkg::axi_resp_e b_resp_o,
    input  logic                   b_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import dma_bus_pkg::*;

    // Responses of accepted bursts, then of completed bursts
    axi_resp_e aw_q[$];
    axi_resp_e b_q[$];

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (aw_valid_i && aw_ready_o) begin
                aw_q.push_back((aw_addr_i >= win_lo_i && aw_addr_i <= win_hi_i) ? SLVERR : OKAY);
            end
            if (w_valid_i && w_ready_o && w_last_i) b_q.push_back(aw_q.pop_front());
            if (b_valid_o && b_ready_i) void'(b_q.pop_front());
        end
    end

    always @(negedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            {aw_ready_o, w_ready_o, b_valid_o} <= '0;
            b_resp_o <= OKAY;
        end else begin
            aw_ready_o <= ($urandom % 2) != 0;
            w_ready_o  <= ($urandom % 4) != 0;
            b_valid_o  <= (b_q.size() != 0);
            b_resp_o   <= (b_q.size() != 0) ? b_q[0] : OKAY;
        end
    end
endmodule

//--- sim/tb_dma_backend.sv
// ----------------------------------------
// Copy engine testbench
// Replays the stim file through the DUT, predicts
// AW, W and responses, and prints a summary
// ----------------------------------------
module tb_dma_backend;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_cfg_pkg::*;
    import dma_bus_pkg::*;

    localparam int ClkPeriod = 40;
    localparam int MaxTests  = 16;

    logic clk_i, rst_n_i;
    logic req_valid_i, req_ready_o, req_last_i;
    addr_t req_src_addr_i, req_dst_addr_i;
    tf_len_t req_length_i;
    logic rsp_valid_o, rsp_ready_i, rsp_last_o;
    err_kind_e rsp_err_kind_o;
    logic obi_req_o, obi_gnt_i, obi_rvalid_i;
    addr_t obi_addr_o;
    data_t obi_rdata_i;
    logic aw_valid_o, aw_ready_i, w_valid_o, w_last_o, w_ready_i, b_valid_i, b_ready_o;
    addr_t aw_addr_o;
    beats_t aw_len_o;
    data_t w_data_o;
    strb_t w_strb_o;
    axi_resp_e b_resp_i;
    logic [2:0] busy_o;

    // Header entry, then src dst len last err per entry
    logic [63:0] stim_mem [MaxTests+1];
    addr_t win_lo, win_hi;
    addr_t exp_aw_addr[$];
    beats_t exp_aw_len[$];
    data_t exp_data[$];
    strb_t exp_strb[$];
    logic exp_wlast[$];
    err_kind_e exp_err[$];
    logic exp_last[$];
    int num_tests, errors, checks, rsp_seen, obi_grants, exp_reads;
    logic loaded;

    dma_backend dut0 (.*);

    obi_mem_model mem0 (
        .clk_i, .rst_n_i, .req_i(obi_req_o), .addr_i(obi_addr_o),
        .gnt_o(obi_gnt_i), .rvalid_o(obi_rvalid_i), .rdata_o(obi_rdata_i)
    );

    axi_wr_slave_model slv0 (
        .clk_i, .rst_n_i, .win_lo_i(win_lo), .win_hi_i(win_hi),
        .aw_valid_i(aw_valid_o), .aw_addr_i(aw_addr_o), .aw_ready_o(aw_ready_i),
        .w_valid_i(w_valid_o), .w_last_i(w_last_o), .w_ready_o(w_ready_i),
        .b_valid_o(b_valid_i), .b_resp_o(b_resp_i), .b_ready_i(b_ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(ClkPeriod/2) clk_i = ~clk_i;
    end

    // Source memory contents as a function of the whole word address
    function automatic data_t expect_word(addr_t a);
        return {a ^ 16'hc3a5, ~a};
    endfunction

    task automatic check_aw(addr_t got_a, beats_t got_l, addr_t exp_a, beats_t exp_l);
        checks++;
        if (got_a !== exp_a || got_l !== exp_l) begin
            errors++;
            $display("FAIL @%0t: AW addr %h len %0d, expected addr %h len %0d",
                     $time, got_a, got_l, exp_a, exp_l);
        end
    endtask

    task automatic check_beat(data_t got_d, strb_t got_s, logic got_l,
                              data_t exp_d, strb_t exp_s, logic exp_l);
        checks++;
        if (got_d !== exp_d || got_s !== exp_s || got_l !== exp_l) begin
            errors++;
            $display("FAIL @%0t: W data %h strb %b last %b, expected %h %b %b",
                     $time, got_d, got_s, got_l, exp_d, exp_s, exp_l);
        end
    endtask

    task automatic check_rsp(err_kind_e got_e, logic got_l, err_kind_e exp_e, logic exp_l);
        checks++;
        if (got_e !== exp_e || got_l !== exp_l) begin
            errors++;
            $display("FAIL @%0t: response %s last %b, expected %s last %b",
                     $time, got_e.name(), got_l, exp_e.name(), exp_l);
        end
    endtask

    // Queue the predicted traffic, then present the request until accepted
    task automatic send_request(logic [63:0] e);
        addr_t src, dst, rd;
        tf_len_t len;
        int beats, first_b, end_b, byte_a;
        strb_t s;
        src = e[63:48];
        dst = e[47:32];
        len = e[27:16];
        exp_err.push_back(err_kind_e'(e[1:0]));
        exp_last.push_back(e[8]);
        if (len != '0) begin
            // Destination bytes covered, end is one past the last byte
            first_b = int'(dst);
            end_b   = int'(dst) + int'(len);
            beats   = ((end_b - 1) / 4) - (first_b / 4) + 1;
            exp_aw_addr.push_back(dst);
            exp_aw_len.push_back(beats_t'(beats - 1));
            for (int i = 0; i < beats; i++) begin
                // A lane is written when its byte lies inside the transfer
                for (int j = 0; j < 4; j++) begin
                    byte_a = (first_b / 4 + i) * 4 + j;
                    s[j]   = (byte_a >= first_b) && (byte_a < end_b);
                end
                rd = {src[15:2], 2'b00} + addr_t'(4 * i);
                exp_data.push_back(expect_word(rd));
                exp_strb.push_back(s);
                exp_wlast.push_back(i == beats - 1);
            end
            exp_reads += beats;
        end
        @(negedge clk_i);
        req_valid_i    = 1'b1;
        req_src_addr_i = src;
        req_dst_addr_i = dst;
        req_length_i   = len;
        req_last_i     = e[8];
        do @(posedge clk_i); while (!req_ready_o);
    endtask

    // Bus monitors sampled at the rising edge
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (obi_req_o && obi_gnt_i) obi_grants++;
            if (aw_valid_o && aw_ready_i) begin
                if (exp_aw_addr.size() == 0) begin
                    errors++;
                    $display("FAIL @%0t: AW issued with no burst expected", $time);
                end else begin
                    check_aw(aw_addr_o, aw_len_o, exp_aw_addr.pop_front(), exp_aw_len.pop_front());
                end
            end
            if (w_valid_o && w_ready_i) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("FAIL @%0t: W beat with no beat expected", $time);
                end else begin
                    check_beat(w_data_o, w_strb_o, w_last_o, exp_data.pop_front(),
                               exp_strb.pop_front(), exp_wlast.pop_front());
                end
            end
            if (rsp_valid_o && rsp_ready_i) begin
                if (exp_err.size() == 0) begin
                    errors++;
                    $display("FAIL @%0t: response with no transfer outstanding", $time);
                end else begin
                    // A transfer that reached the bus takes its B with its response
                    if ((b_valid_i && b_ready_o) != (exp_err[0] != ERR_ZERO_LEN)) begin
                        errors++;
                        $display("FAIL @%0t: B handshake %b with response, expected %b",
                                 $time, b_valid_i && b_ready_o, exp_err[0] != ERR_ZERO_LEN);
                    end
                    check_rsp(rsp_err_kind_o, rsp_last_o, exp_err.pop_front(),
                              exp_last.pop_front());
                end
                $display("test %0d done at %0t: %s last %b",
                         rsp_seen, $time, rsp_err_kind_o.name(), rsp_last_o);
                rsp_seen++;
            end else if (b_valid_i && b_ready_o) begin
                errors++;
                $display("FAIL @%0t: B accepted with no response handed over", $time);
            end
        end
    end

    // Random response back-pressure
    initial begin
        forever @(negedge clk_i) rsp_ready_i <= rst_n_i && ($urandom % 4 != 0);
    end

    // Watchdog sized from the number of stim lines
    initial begin
        wait (loaded);
        #(num_tests * 300 * ClkPeriod);
        $display("Watchdog expired, the run timed out before all responses arrived");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'h6a99));
        {req_valid_i, req_last_i, rsp_ready_i, rst_n_i} = '0;
        {req_src_addr_i, req_dst_addr_i, req_length_i} = '0;
        {errors, checks, rsp_seen, obi_grants, exp_reads} = '0;
        loaded = 1'b0;
        $readmemh("sim/dma_stim.txt", stim_mem);
        win_lo    = stim_mem[0][63:48];
        win_hi    = stim_mem[0][47:32];
        num_tests = int'(stim_mem[0][31:16]);
        loaded    = 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i) rst_n_i = 1'b1;
        for (int t = 0; t < num_tests; t++) send_request(stim_mem[t+1]);
        @(negedge clk_i) req_valid_i = 1'b0;
        wait (rsp_seen == num_tests);
        repeat (2) @(negedge clk_i);
        if (busy_o !== 3'b000) begin
            errors++;
            $display("FAIL @%0t: busy_o is %b after all transfers", $time, busy_o);
        end
        if (obi_grants != exp_reads) begin
            errors++;
            $display("FAIL @%0t: %0d OBI reads granted, %0d expected",
                     $time, obi_grants, exp_reads);
        end
        if (exp_aw_addr.size() != 0 || exp_data.size() != 0) begin
            errors++;
            $display("FAIL @%0t: %0d bursts and %0d beats expected but never seen",
                     $time, exp_aw_addr.size(), exp_data.size());
        end
        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim/dma_stim.txt
// Entry 0: error window low, error window high, test count, unused
// Then per test: src dst len(bytes) last(8 bits) expected err_kind (8 bits)
8000_8fff_000b_0000
0100_2000_0004_00_00
0203_3003_000b_00_00
0400_4000_0000_01_01
0500_8010_0010_00_02
0600_5001_001e_01_00
0700_6000_0040_00_00
0802_6102_0005_01_00
0900_8200_0008_00_02
0a03_6203_0001_00_00
0b00_6300_0000_00_01
0c01_6401_0003_01_00

//--- project.f
hdl/dma_cfg_pkg.sv
hdl/dma_bus_pkg.sv
hdl/dma_desc_if.sv
hdl/dma_decode.sv
hdl/dma_execute.sv
hdl/dma_result.sv
hdl/dma_backend.sv
sim/tb_bus_models.sv
sim/tb_dma_backend.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the copy engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_dma_backend \
    -f project.f

out=$(./obj_dir/Vtb_dma_backend)
echo "$out"

# The pass message decides the exit status
echo "$out" | grep -q '\*\*\* TEST PASSED \*\*\*'
